//--- common/dcache_defs.svh
// Cache geometry macros; include in any file that sizes cache addresses or arrays
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Word address of the 16-bit CPU over a 1 MB byte space
`define DCACHE_ADDR_BITS 19

// Set count and set index width
`define DCACHE_SETS 256
`define DCACHE_INDEX_BITS 8

// Words per line and word offset width
`define DCACHE_LINE_WORDS 8
`define DCACHE_OFFSET_BITS 3

// Tag takes the address bits above index and offset
`define DCACHE_TAG_BITS (`DCACHE_ADDR_BITS - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)

// Associativity of the cache
`define DCACHE_WAYS 2

// Words held by one way
`define DCACHE_WAY_WORDS (`DCACHE_SETS * `DCACHE_LINE_WORDS)

// Word address inside one way (index and offset)
`define DCACHE_LINE_ADDR_BITS (`DCACHE_INDEX_BITS + `DCACHE_OFFSET_BITS)

`endif

//--- common/dcache_pkg.sv
// Struct types of the data cache; compile first and import where the types are used
`include "dcache_defs.svh"

`default_nettype none

package dcache_pkg;

    // Word address as the cache splits it
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0]    tag;
        logic [`DCACHE_INDEX_BITS-1:0]  index;
        logic [`DCACHE_OFFSET_BITS-1:0] offset;
    } cache_addr_t;

    // One CPU access, held steady until ack
    typedef struct packed {
        cache_addr_t addr;
        logic [15:0] wdata;
        logic [1:0]  bytesel;
        logic        write;
    } cpu_req_t;

    // One memory beat, always a full word
    typedef struct packed {
        logic [`DCACHE_ADDR_BITS-1:0] addr;
        logic [15:0]                  wdata;
        logic                         write;
    } mem_req_t;

    // Stored state of one way in one set
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0] tag;
        logic                        valid;
        logic                        dirty;
    } way_meta_t;

    // Registered result of a tag lookup
    typedef struct packed {
        way_meta_t [`DCACHE_WAYS-1:0] way;
        logic                         lru;
        logic                         hit;
        logic                         hit_way;
    } lookup_t;

endpackage

`default_nettype wire

//--- dcache/dcache_tag_store.sv
// Tag, valid, dirty and LRU state of the data cache with a registered lookup port
`include "dcache_defs.svh"

`default_nettype none

module dcache_tag_store (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    lookup_en,
    input  dcache_pkg::cache_addr_t addr,
    input  logic                    meta_we,
    input  logic                    meta_way,
    input  dcache_pkg::way_meta_t   meta_wdata,
    input  logic                    lru_we,
    input  logic                    lru_wdata,
    output dcache_pkg::lookup_t     lookup
);

    import dcache_pkg::*;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    logic [`DCACHE_TAG_BITS-1:0] tag_mem [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]     valid_bits [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0]     dirty_bits [`DCACHE_WAYS];

    // Per set, the way to replace next
    logic [`DCACHE_SETS-1:0]     lru_bits;

    way_meta_t                   meta_rd [`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0]     match;

    // Tag written along with the rest of the way's metadata
    always_ff @(posedge clk) begin
        if (meta_we) begin
            tag_mem[meta_way][addr.index] <= meta_wdata.tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
            lru_bits <= '0;
        end else begin
            if (meta_we) begin
                valid_bits[meta_way][addr.index] <= meta_wdata.valid;
                dirty_bits[meta_way][addr.index] <= meta_wdata.dirty;
            end
            if (lru_we) begin
                lru_bits[addr.index] <= lru_wdata;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------------------

    // Read both ways of the addressed set and compare tags
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            meta_rd[w].tag   = tag_mem[w][addr.index];
            meta_rd[w].valid = valid_bits[w][addr.index];
            meta_rd[w].dirty = dirty_bits[w][addr.index];
            match[w]         = meta_rd[w].valid && (meta_rd[w].tag == addr.tag);
        end
    end

    // Result holds until the next lookup_en
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lookup <= '0;
        end else if (lookup_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                lookup.way[w] <= meta_rd[w];
            end
            lookup.lru     <= lru_bits[addr.index];
            lookup.hit     <= |match;
            // Only way 1 matching means way 1
            lookup.hit_way <= match[1];
        end
    end

endmodule

`default_nettype wire

//--- dcache/dcache_data_store.sv
// Line data of both cache ways; byte-enabled write port and registered read port
`include "dcache_defs.svh"

`default_nettype none

module dcache_data_store (
    input  logic                              clk,
    input  logic                              rd_way,
    input  logic [`DCACHE_LINE_ADDR_BITS-1:0] rd_addr,
    input  logic                              we,
    input  logic                              wr_way,
    input  logic [`DCACHE_LINE_ADDR_BITS-1:0] wr_addr,
    input  logic [15:0]                       wdata,
    input  logic [1:0]                        be,
    output logic [15:0]                       rdata
);

    // ------------------------------------------------------------------------
    // Way arrays
    // ------------------------------------------------------------------------

    logic [15:0] way_mem [`DCACHE_WAYS][`DCACHE_WAY_WORDS];
    logic [15:0] rd_q [`DCACHE_WAYS];

    // Byte lanes written separately under be
    always_ff @(posedge clk) begin
        if (we) begin
            if (be[0]) begin
                way_mem[wr_way][wr_addr][7:0] <= wdata[7:0];
            end
            if (be[1]) begin
                way_mem[wr_way][wr_addr][15:8] <= wdata[15:8];
            end
        end
    end

    // Both ways are read every cycle so the hit way can be chosen
    // after the tag compare, one cycle later
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            rd_q[w] <= way_mem[w][rd_addr];
        end
    end

    assign rdata = rd_q[rd_way];

endmodule

`default_nettype wire

//--- dcache/dcache_ctrl.sv
// Data cache FSM; runs lookups, write-back and fill beats, and acks the CPU
`include "dcache_defs.svh"

`default_nettype none

module dcache_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              access,
    input  dcache_pkg::cpu_req_t              cpu_req,
    input  dcache_pkg::lookup_t               lookup,
    input  logic [15:0]                       data_rdata,
    input  logic                              mem_ack,
    input  logic [15:0]                       mem_rdata,
    output logic                              ack,
    output logic [15:0]                       rdata,
    output logic                              lookup_en,
    output logic                              meta_we,
    output logic                              meta_way,
    output dcache_pkg::way_meta_t             meta_wdata,
    output logic                              lru_we,
    output logic                              lru_wdata,
    output logic                              data_rd_way,
    output logic [`DCACHE_LINE_ADDR_BITS-1:0] data_rd_addr,
    output logic                              data_we,
    output logic                              data_wr_way,
    output logic [`DCACHE_LINE_ADDR_BITS-1:0] data_wr_addr,
    output logic [15:0]                       data_wdata,
    output logic [1:0]                        data_be,
    output logic                              mem_access,
    output dcache_pkg::mem_req_t              mem_req
);

    import dcache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_RESPOND,
        ST_WB_READ,
        ST_WB_BEAT,
        ST_FILL,
        ST_REPLAY
    } state_t;

    state_t                         state;
    state_t                         state_next;
    logic [`DCACHE_OFFSET_BITS-1:0] beat;
    logic                           victim_way;
    logic                           beat_gap;
    logic                           beat_done;
    logic                           last_beat;
    logic                           in_wb;
    logic                           write_hit;
    logic                           fill_wr;
    way_meta_t                      lru_meta;
    way_meta_t                      victim_meta;

    assign lru_meta    = lookup.way[lookup.lru];
    assign victim_meta = lookup.way[victim_way];
    assign beat_done   = mem_access && mem_ack;
    assign last_beat   = &beat;
    assign in_wb       = (state == ST_WB_READ) || (state == ST_WB_BEAT);

    // ------------------------------------------------------------------------
    // State and beat counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            beat       <= '0;
            victim_way <= 1'b0;
            beat_gap   <= 1'b0;
        end else begin
            state    <= state_next;
            // Keeps mem_access low for the cycle after each memory ack
            beat_gap <= beat_done;
            if (state == ST_RESPOND && !lookup.hit) begin
                victim_way <= lookup.lru;
                beat       <= '0;
            end else if (beat_done) begin
                // Wraps to 0 after the last write-back beat, ready for the fill
                beat <= beat + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (access) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: state_next = ST_RESPOND;
            ST_RESPOND: begin
                if (lookup.hit) begin
                    state_next = ST_IDLE;
                end else if (lru_meta.valid && lru_meta.dirty) begin
                    state_next = ST_WB_READ;
                end else begin
                    state_next = ST_FILL;
                end
            end
            ST_WB_READ: state_next = ST_WB_BEAT;
            ST_WB_BEAT: begin
                if (beat_done) begin
                    state_next = last_beat ? ST_FILL : ST_WB_READ;
                end
            end
            ST_FILL: begin
                if (beat_done && last_beat) begin
                    state_next = ST_REPLAY;
                end
            end
            // New tag written here, then the request runs again as a lookup
            ST_REPLAY: state_next = ST_LOOKUP;
            default: state_next = ST_IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // CPU side and stores
    // ------------------------------------------------------------------------

    assign ack       = (state == ST_RESPOND) && lookup.hit;
    assign rdata     = data_rdata;
    assign lookup_en = (state == ST_LOOKUP);
    assign write_hit = ack && cpu_req.write;
    assign fill_wr   = (state == ST_FILL) && beat_done;

    // Every hit makes the other way the next victim
    assign lru_we    = ack;
    assign lru_wdata = ~lookup.hit_way;

    // Hit data in respond, victim words during write-back
    assign data_rd_way  = (state == ST_RESPOND) ? lookup.hit_way : victim_way;
    assign data_rd_addr = {cpu_req.addr.index, in_wb ? beat : cpu_req.addr.offset};

    assign data_we      = write_hit || fill_wr;
    assign data_wr_way  = write_hit ? lookup.hit_way : victim_way;
    assign data_wr_addr = {cpu_req.addr.index, write_hit ? cpu_req.addr.offset : beat};
    assign data_wdata   = write_hit ? cpu_req.wdata : mem_rdata;
    assign data_be      = write_hit ? cpu_req.bytesel : 2'b11;

    always_comb begin
        meta_we    = 1'b0;
        meta_way   = victim_way;
        meta_wdata = victim_meta;
        if (write_hit) begin
            meta_we          = 1'b1;
            meta_way         = lookup.hit_way;
            meta_wdata       = lookup.way[lookup.hit_way];
            meta_wdata.dirty = 1'b1;
        end else if (state == ST_WB_BEAT && beat_done && last_beat) begin
            // Victim is clean once its last word is out
            meta_we          = 1'b1;
            meta_wdata.dirty = 1'b0;
        end else if (state == ST_REPLAY) begin
            meta_we          = 1'b1;
            meta_wdata.tag   = cpu_req.addr.tag;
            meta_wdata.valid = 1'b1;
            meta_wdata.dirty = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Memory side
    // ------------------------------------------------------------------------

    assign mem_access = ((state == ST_WB_BEAT) || (state == ST_FILL)) && !beat_gap;

    always_comb begin
        mem_req.addr  = {(state == ST_WB_BEAT) ? victim_meta.tag : cpu_req.addr.tag,
                         cpu_req.addr.index, beat};
        mem_req.wdata = data_rdata;
        mem_req.write = (state == ST_WB_BEAT);
    end

endmodule

`default_nettype wire

//--- dcache/dcache_top.sv
// Data cache top level; connects CPU and memory ports to the FSM and the stores
`include "dcache_defs.svh"

`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 access,
    input  dcache_pkg::cpu_req_t cpu_req,
    input  logic                 mem_ack,
    input  logic [15:0]          mem_rdata,
    output logic                 ack,
    output logic [15:0]          rdata,
    output logic                 mem_access,
    output dcache_pkg::mem_req_t mem_req
);

    import dcache_pkg::*;

    lookup_t                           lookup;
    logic                              lookup_en;
    logic                              meta_we;
    logic                              meta_way;
    way_meta_t                         meta_wdata;
    logic                              lru_we;
    logic                              lru_wdata;
    logic                              data_rd_way;
    logic [`DCACHE_LINE_ADDR_BITS-1:0] data_rd_addr;
    logic                              data_we;
    logic                              data_wr_way;
    logic [`DCACHE_LINE_ADDR_BITS-1:0] data_wr_addr;
    logic [15:0]                       data_wdata;
    logic [1:0]                        data_be;
    logic [15:0]                       data_rdata;

    // The CPU holds its address for the whole access, so the tag store
    // indexes straight from it
    dcache_tag_store i_tag_store (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .addr       (cpu_req.addr),
        .meta_we    (meta_we),
        .meta_way   (meta_way),
        .meta_wdata (meta_wdata),
        .lru_we     (lru_we),
        .lru_wdata  (lru_wdata),
        .lookup     (lookup)
    );

    dcache_data_store i_data_store (
        .clk     (clk),
        .rd_way  (data_rd_way),
        .rd_addr (data_rd_addr),
        .we      (data_we),
        .wr_way  (data_wr_way),
        .wr_addr (data_wr_addr),
        .wdata   (data_wdata),
        .be      (data_be),
        .rdata   (data_rdata)
    );

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .access       (access),
        .cpu_req      (cpu_req),
        .lookup       (lookup),
        .data_rdata   (data_rdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .ack          (ack),
        .rdata        (rdata),
        .lookup_en    (lookup_en),
        .meta_we      (meta_we),
        .meta_way     (meta_way),
        .meta_wdata   (meta_wdata),
        .lru_we       (lru_we),
        .lru_wdata    (lru_wdata),
        .data_rd_way  (data_rd_way),
        .data_rd_addr (data_rd_addr),
        .data_we      (data_we),
        .data_wr_way  (data_wr_way),
        .data_wr_addr (data_wr_addr),
        .data_wdata   (data_wdata),
        .data_be      (data_be),
        .mem_access   (mem_access),
        .mem_req      (mem_req)
    );

endmodule

`default_nettype wire

//--- verif/dcache_mem_model.sv
// Behavioral backing memory for the data cache testbench; answers each beat after a random delay
`include "dcache_defs.svh"

`default_nettype none

module dcache_mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_access,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_ack,
    output logic [15:0]          mem_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    logic [15:0] mem [1 << `DCACHE_ADDR_BITS];
    logic [15:0] lfsr;
    logic [15:0] lfsr_1;
    logic [15:0] lfsr_2;
    logic [1:0]  delay;
    logic [1:0]  waited;
    logic        answer;

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Every word starts from a pattern of its own address
    initial begin
        for (int a = 0; a < (1 << `DCACHE_ADDR_BITS); a++) begin
            mem[a] = a[15:0] ^ 16'hA5C3;
        end
    end

    assign lfsr_1 = lfsr_step(lfsr);
    assign lfsr_2 = lfsr_step(lfsr_1);
    assign answer = mem_access && !mem_ack && (waited == delay);

    always @(posedge clk) begin
        if (answer && mem_req.write) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Beat handshake with 0 to 3 cycles of delay
    // ------------------------------------------------------------------------

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr      <= 16'd43;
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            delay     <= 2'd0;
            waited    <= 2'd0;
        end else if (mem_ack) begin
            // Draw the delay of the next beat
            mem_ack <= 1'b0;
            waited  <= 2'd0;
            delay   <= {lfsr_1[0], lfsr_2[0]};
            lfsr    <= lfsr_2;
        end else if (answer) begin
            mem_ack <= 1'b1;
            if (!mem_req.write) begin
                mem_rdata <= mem[mem_req.addr];
            end
        end else if (mem_access) begin
            waited <= waited + 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- verif/dcache_tb.sv
// Testbench top for the data cache; runs directed and random accesses against a shadow memory
`include "dcache_defs.svh"

`default_nettype none

module dcache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    logic        clk;
    logic        reset;
    logic        access;
    cpu_req_t    cpu_req;
    logic        ack;
    logic [15:0] rdata;
    logic        mem_access;
    mem_req_t    mem_req;
    logic        mem_ack;
    logic [15:0] mem_rdata;

    logic [15:0] shadow [1 << `DCACHE_ADDR_BITS];
    mem_req_t    beats[$];
    logic [15:0] rng;
    logic [15:0] rdata_seen;
    int          latency;
    int          issued;
    int          cycles;

    dcache_top i_dcache_top (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .cpu_req    (cpu_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .ack        (ack),
        .rdata      (rdata),
        .mem_access (mem_access),
        .mem_req    (mem_req)
    );

    dcache_mem_model i_mem_model (
        .clk        (clk),
        .reset      (reset),
        .mem_access (mem_access),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reference, checks and helpers
    // ------------------------------------------------------------------------

    function automatic logic [15:0] expected_read(input cache_addr_t addr);
        return shadow[addr];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic cache_addr_t make_addr(input logic [`DCACHE_TAG_BITS-1:0] tag,
                                              input logic [7:0] index,
                                              input logic [2:0] offset);
        return {tag, index, offset};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = rng[0] ? ((rng >> 1) ^ 16'hB400) : (rng >> 1);
            v   = {v[14:0], rng[0]};
        end
        return v;
    endfunction

    function automatic int count_beats(input logic write);
        int n;
        n = 0;
        foreach (beats[i]) begin
            if (beats[i].write == write) begin
                n++;
            end
        end
        return n;
    endfunction

    // One CPU access; reads are compared, writes update the shadow memory
    task automatic access_cache(input cache_addr_t addr, input logic write,
                                input logic [15:0] wdata, input logic [1:0] bsel);
        beats.delete();
        @(posedge clk);
        cpu_req <= '{addr: addr, wdata: wdata, bytesel: bsel, write: write};
        access  <= 1'b1;
        issued++;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!ack);
        rdata_seen = rdata;
        @(posedge clk);
        access <= 1'b0;
        if (write) begin
            if (bsel[0]) shadow[addr][7:0] = wdata[7:0];
            if (bsel[1]) shadow[addr][15:8] = wdata[15:8];
        end else begin
            check_value("rdata", 32'(rdata_seen), 32'(expected_read(addr)));
        end
    endtask

    // Memory beats of the current request, in order
    always @(negedge clk) begin
        if (!reset && mem_access && mem_ack) begin
            beats.push_back(mem_req);
        end
    end

    // Budget of 64 cycles per request plus reset
    always @(posedge clk) begin
        cycles++;
        if (cycles > 16 + 64 * (issued + 1)) begin
            $display("Timeout: the cache stopped answering within the cycle limit");
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        cache_addr_t a;
        logic [1:0]  bsel;
        access  <= 1'b0;
        cpu_req <= '0;
        reset   <= 1'b1;
        rng     = 16'd43;
        issued  = 0;
        cycles  = 0;
        for (int i = 0; i < (1 << `DCACHE_ADDR_BITS); i++) begin
            shadow[i] = i[15:0] ^ 16'hA5C3;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Cold read fills the line, second read hits
        access_cache(make_addr(8'd5, 8'h10, 3'd3), 1'b0, 16'h0, 2'b11);
        check_value("read beats", count_beats(1'b0), 8);
        check_value("write beats", count_beats(1'b1), 0);
        foreach (beats[i]) begin
            check_value("fill addr", 32'(beats[i].addr), 32'(make_addr(8'd5, 8'h10, i[2:0])));
        end
        access_cache(make_addr(8'd5, 8'h10, 3'd6), 1'b0, 16'h0, 2'b11);
        check_value("hit beats", beats.size(), 0);
        check_value("hit latency", latency, 3);

        // Byte selects
        a = make_addr(8'd7, 8'h11, 3'd2);
        access_cache(a, 1'b1, 16'h1234, 2'b01);
        access_cache(a, 1'b0, 16'h0, 2'b11);
        access_cache(a, 1'b1, 16'h5678, 2'b10);
        access_cache(a, 1'b0, 16'h0, 2'b11);
        access_cache(a, 1'b1, 16'h9ABC, 2'b11);
        access_cache(a, 1'b0, 16'h0, 2'b11);

        // LRU in set 0x20 with tags 1, 2, 3
        access_cache(make_addr(8'd1, 8'h20, 3'd0), 1'b0, 16'h0, 2'b11);
        access_cache(make_addr(8'd2, 8'h20, 3'd0), 1'b0, 16'h0, 2'b11);
        access_cache(make_addr(8'd1, 8'h20, 3'd1), 1'b0, 16'h0, 2'b11);
        access_cache(make_addr(8'd3, 8'h20, 3'd0), 1'b0, 16'h0, 2'b11);
        check_value("C fill beats", count_beats(1'b0), 8);
        access_cache(make_addr(8'd1, 8'h20, 3'd2), 1'b0, 16'h0, 2'b11);
        check_value("A beats", beats.size(), 0);
        access_cache(make_addr(8'd2, 8'h20, 3'd2), 1'b0, 16'h0, 2'b11);
        check_value("B fill beats", count_beats(1'b0), 8);

        // Dirty eviction writes the line back before the fill
        access_cache(make_addr(8'd1, 8'h30, 3'd4), 1'b1, 16'hBEEF, 2'b11);
        access_cache(make_addr(8'd2, 8'h30, 3'd0), 1'b0, 16'h0, 2'b11);
        access_cache(make_addr(8'd3, 8'h30, 3'd0), 1'b0, 16'h0, 2'b11);
        check_value("evict beats", beats.size(), 16);
        for (int i = 0; i < 8; i++) begin
            a = make_addr(8'd1, 8'h30, i[2:0]);
            check_value("wb write flag", 32'(beats[i].write), 32'd1);
            check_value("wb addr", 32'(beats[i].addr), 32'(a));
            check_value("wb data", 32'(beats[i].wdata), 32'(expected_read(a)));
            check_value("fill write flag", 32'(beats[i + 8].write), 32'd0);
        end
        access_cache(make_addr(8'd4, 8'h30, 3'd0), 1'b0, 16'h0, 2'b11);
        check_value("clean evict writes", count_beats(1'b1), 0);

        // Random accesses over sets 0x40 to 0x43
        for (int n = 0; n < 400; n++) begin
            a    = make_addr(8'(random_bits(2)), 8'h40 + 8'(random_bits(2)), 3'(random_bits(3)));
            bsel = 2'(random_bits(2));
            if (bsel == 2'b00) bsel = 2'b11;
            access_cache(a, random_bits(1) == 16'd1, random_bits(16), bsel);
        end
        for (int s = 0; s < 4; s++) begin
            access_cache(make_addr(8'hF0, 8'h40 + 8'(s), 3'd0), 1'b0, 16'h0, 2'b11);
            access_cache(make_addr(8'hF1, 8'h40 + 8'(s), 3'd0), 1'b0, 16'h0, 2'b11);
        end
        for (int t = 0; t < 4; t++) begin
            for (int s = 0; s < 4; s++) begin
                for (int o = 0; o < 8; o++) begin
                    a = make_addr(8'(t), 8'h40 + 8'(s), 3'(o));
                    check_value("memory word", 32'(i_mem_model.mem[a]), 32'(shadow[a]));
                end
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache.f
+incdir+common
common/dcache_pkg.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dcache.f --top-module dcache_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/Vdcache_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit $status
fi

exit 0
